/* hdl/tx_crc32_bank.sv */
// ethernet crc-32 bank
`timescale 1ns/1ps

module tx_crc32_bank (
    input  logic                             clk,
    input  logic                             crc_init,
    input  logic                             crc_update,
    input  logic [xgmii_tx_pkg::DATA_W-1:0]  cap_data,
    output xgmii_tx_pkg::crc_bank_t          crc_next,
    output xgmii_tx_pkg::crc_bank_t          crc_held
);

    import xgmii_tx_pkg::*;

    localparam logic [31:0] CRC_POLY = 32'h04c11db7;
    // lsb-first form of the polynomial
    localparam logic [31:0] CRC_POLY_REV = {<<{CRC_POLY}};

    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] data);
        logic [31:0] crc;
        crc = crc_in ^ {24'h000000, data};
        for (int b = 0; b < 8; b++) begin
            crc = crc[0] ? ((crc >> 1) ^ CRC_POLY_REV) : (crc >> 1);
        end
        return crc;
    endfunction

    // chain from the running state through bytes 0..7
    always_comb begin
        logic [31:0] acc;
        acc = crc_held[CTRL_W-1];
        for (int n = 0; n < CTRL_W; n++) begin
            acc = crc_byte(acc, cap_data[8*n +: 8]);
            crc_next[n] = acc;
        end
    end

    always_ff @(posedge clk) begin
        for (int n = 0; n < CTRL_W - 1; n++) begin
            crc_held[n] <= crc_next[n];
        end
        // last entry doubles as the running state
        if (crc_init) begin
            crc_held[CTRL_W-1] <= '1;
        end else if (crc_update) begin
            crc_held[CTRL_W-1] <= crc_next[CTRL_W-1];
        end
    end

endmodule

/* hdl/tx_frame_ctrl.sv */
// transmit frame controller
`timescale 1ns/1ps

module tx_frame_ctrl #(
    parameter bit PADDING_EN = 1'b1,
    parameter int MIN_FRAME_LEN = 64
) (
    input  logic                                  clk,
    input  logic                                  reset_crc,
    input  xgmii_tx_pkg::tx_beat_t                s_beat,
    input  logic                                  s_tvalid,
    output logic                                  s_tready,
    input  logic [7:0]                            cfg_ifg,
    input  logic                                  cfg_tx_enable,
    input  xgmii_tx_pkg::term_words_t             term,
    output logic                                  crc_init,
    output logic                                  crc_update,
    output logic [xgmii_tx_pkg::DATA_W-1:0]       cap_data,
    output logic [xgmii_tx_pkg::EMPTY_W-1:0]      cap_empty,
    output xgmii_tx_pkg::xgmii_word_t             xgmii_out,
    output logic                                  start_packet,
    output logic                                  error_underflow
);

    import xgmii_tx_pkg::*;

    // bytes before the fcs that a frame must reach
    localparam int NEED_BYTES = MIN_FRAME_LEN - 4;
    localparam int NEED_W = $clog2(NEED_BYTES + 1);

    localparam xgmii_word_t IDLE_WORD = '{txd: {CTRL_W{XGMII_IDLE}}, txc: 8'hff};
    localparam xgmii_word_t START_WORD = '{txd: {ETH_SFD, {6{ETH_PRE}}, XGMII_START},
                                           txc: 8'h01};
    localparam xgmii_word_t ERROR_WORD = '{txd: {XGMII_TERM, {7{XGMII_ERROR}}}, txc: 8'hff};

    tx_state_e          state_reg, state_next;
    logic               frame_reg, frame_next;
    logic               frame_start_reg, frame_start_next;
    logic               underflow_reg, underflow_next;
    logic [NEED_W-1:0]  min_count_reg, min_count_next;
    logic [7:0]         ifg_reg, ifg_next;
    logic               tready_next;
    xgmii_word_t        xgmii_next;
    logic [DATA_W-1:0]  cap_data_next;
    logic [EMPTY_W-1:0] cap_empty_next;

    logic [DATA_W-1:0]  beat_masked;
    logic [EMPTY_W-1:0] beat_empty;
    logic [NEED_W-1:0]  need_cur;
    logic [NEED_W-1:0]  need_rest;
    logic [EMPTY_W-1:0] pad_empty;
    tx_state_e          end_state;
    logic [EMPTY_W-1:0] end_empty;
    logic [7:0]         gap_min;
    logic [7:0]         ifg_dec;

    // contiguous tkeep from lane 0 to empty byte count
    function automatic logic [EMPTY_W-1:0] keep_to_empty(input logic [CTRL_W-1:0] keep);
        logic [EMPTY_W-1:0] empty;
        empty = EMPTY_W'(CTRL_W - 1);
        for (int i = 0; i < CTRL_W; i++) begin
            if (keep[i]) begin
                empty = EMPTY_W'(CTRL_W - 1 - i);
            end
        end
        return empty;
    endfunction

    always_comb begin
        for (int i = 0; i < CTRL_W; i++) begin
            beat_masked[8*i +: 8] = s_beat.tkeep[i] ? s_beat.tdata[8*i +: 8] : 8'h00;
        end
    end

    assign beat_empty = keep_to_empty(s_beat.tkeep);
    assign gap_min = (cfg_ifg > MIN_IFG) ? cfg_ifg : MIN_IFG;
    assign ifg_dec = (ifg_reg > 8'd8) ? ifg_reg - 8'd8 : 8'd0;

    // where the frame goes after the word being captured now
    always_comb begin
        need_cur = (state_reg == IDLE) ? NEED_W'(NEED_BYTES) : min_count_reg;
        need_rest = (need_cur > NEED_W'(CTRL_W)) ? need_cur - NEED_W'(CTRL_W) : '0;
        pad_empty = EMPTY_W'(CTRL_W - need_cur);
        if (!s_tvalid || s_beat.tuser) begin
            end_state = ERR;
            end_empty = beat_empty;
        end else if (PADDING_EN && need_cur > NEED_W'(CTRL_W)) begin
            end_state = PAD;
            end_empty = '0;
        end else if (PADDING_EN && need_cur != '0 && beat_empty > pad_empty) begin
            // short final beat, extend it with zero bytes
            end_state = FCS_1;
            end_empty = pad_empty;
        end else begin
            end_state = FCS_1;
            end_empty = beat_empty;
        end
    end

    always_comb begin
        state_next = state_reg;
        frame_next = frame_reg;
        frame_start_next = 1'b0;
        underflow_next = 1'b0;
        min_count_next = min_count_reg;
        ifg_next = ifg_reg;
        tready_next = 1'b0;
        xgmii_next = IDLE_WORD;
        cap_data_next = cap_data;
        cap_empty_next = cap_empty;
        crc_init = 1'b0;
        crc_update = 1'b0;

        if (s_tvalid && s_tready) begin
            frame_next = !s_beat.tlast;
        end

        case (state_reg)
            IDLE: begin
                crc_init = 1'b1;
                tready_next = cfg_tx_enable;
                cap_data_next = beat_masked;
                cap_empty_next = beat_empty;
                min_count_next = need_rest;
                if (s_tvalid && s_tready) begin
                    xgmii_next = START_WORD;
                    frame_start_next = 1'b1;
                    tready_next = frame_next;
                    if (s_beat.tlast) begin
                        cap_empty_next = end_empty;
                        state_next = end_state;
                    end else begin
                        state_next = PAYLOAD;
                    end
                end
            end
            PAYLOAD: begin
                crc_update = 1'b1;
                tready_next = 1'b1;
                xgmii_next = '{txd: cap_data, txc: 8'h00};
                cap_data_next = beat_masked;
                cap_empty_next = beat_empty;
                min_count_next = need_rest;
                if (!s_tvalid || s_beat.tlast) begin
                    // on underflow tready stays up to drain the frame
                    tready_next = frame_next;
                    underflow_next = !s_tvalid;
                    cap_empty_next = end_empty;
                    state_next = end_state;
                end
            end
            PAD: begin
                crc_update = 1'b1;
                tready_next = frame_next;
                xgmii_next = '{txd: cap_data, txc: 8'h00};
                cap_data_next = '0;
                cap_empty_next = '0;
                min_count_next = need_rest;
                if (need_cur <= NEED_W'(CTRL_W)) begin
                    cap_empty_next = pad_empty;
                    state_next = FCS_1;
                end
            end
            FCS_1: begin
                crc_update = 1'b1;
                tready_next = frame_next;
                xgmii_next = term.word0;
                ifg_next = gap_min - term.ifg_offset;
                state_next = term.two_words ? FCS_2 : IFG;
            end
            FCS_2: begin
                tready_next = frame_next;
                xgmii_next = term.word1;
                state_next = IFG;
            end
            ERR: begin
                tready_next = frame_next;
                xgmii_next = ERROR_WORD;
                ifg_next = gap_min;
                state_next = IFG;
            end
            IFG: begin
                tready_next = frame_next;
                ifg_next = ifg_dec;
                // hold here until gap is done and any dropped frame is drained
                if (ifg_dec == 8'd0 && !frame_reg) begin
                    tready_next = cfg_tx_enable;
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state_reg <= IDLE;
            frame_reg <= 1'b0;
            frame_start_reg <= 1'b0;
            underflow_reg <= 1'b0;
            min_count_reg <= '0;
            ifg_reg <= 8'd0;
            s_tready <= 1'b0;
            xgmii_out <= IDLE_WORD;
            start_packet <= 1'b0;
            error_underflow <= 1'b0;
        end else begin
            state_reg <= state_next;
            frame_reg <= frame_next;
            frame_start_reg <= frame_start_next;
            underflow_reg <= underflow_next;
            min_count_reg <= min_count_next;
            ifg_reg <= ifg_next;
            s_tready <= tready_next;
            xgmii_out <= xgmii_next;
            start_packet <= frame_start_reg;
            // lines up with the error word on the output
            error_underflow <= underflow_reg;
        end
    end

    always_ff @(posedge clk) begin
        cap_data <= cap_data_next;
        cap_empty <= cap_empty_next;
    end

endmodule

/* hdl/tx_term_encoder.sv */
// fcs and terminate encoder
`timescale 1ns/1ps

module tx_term_encoder (
    input  logic [xgmii_tx_pkg::DATA_W-1:0]   cap_data,
    input  logic [xgmii_tx_pkg::EMPTY_W-1:0]  cap_empty,
    input  xgmii_tx_pkg::crc_bank_t           crc_next,
    input  xgmii_tx_pkg::crc_bank_t           crc_held,
    output xgmii_tx_pkg::term_words_t         term
);

    import xgmii_tx_pkg::*;

    // byte stream across both words, lane 0 of word0 first
    logic [2*CTRL_W-1:0][7:0] lane_byte;
    logic [2*CTRL_W-1:0]      lane_ctrl;
    logic [3:0]               data_bytes;
    logic [31:0]              fcs_word0;
    logic [31:0]              fcs_word1;
    logic [31:0]              fcs_pick;
    logic                     two_words;

    always_comb begin
        data_bytes = 4'(CTRL_W) - 4'(cap_empty);

        // crc index is data_bytes - 1, which is the inverted empty count
        // word0 is sent this cycle, word1 one cycle later from the held copy
        fcs_word0 = ~crc_next[~cap_empty];
        fcs_word1 = ~crc_held[~cap_empty];

        two_words = (cap_empty <= 3'd4);
        fcs_pick = fcs_word0;

        for (int i = 0; i < 2*CTRL_W; i++) begin
            fcs_pick = (i < CTRL_W) ? fcs_word0 : fcs_word1;
            if (i < data_bytes) begin
                lane_byte[i] = cap_data[8*(i % CTRL_W) +: 8];
                lane_ctrl[i] = 1'b0;
            end else if (i < data_bytes + 4) begin
                lane_byte[i] = fcs_pick[8*(i - data_bytes) +: 8];
                lane_ctrl[i] = 1'b0;
            end else if (i == data_bytes + 4) begin
                lane_byte[i] = XGMII_TERM;
                lane_ctrl[i] = 1'b1;
            end else begin
                lane_byte[i] = XGMII_IDLE;
                lane_ctrl[i] = 1'b1;
            end
        end

        term.word0.txd = lane_byte[CTRL_W-1:0];
        term.word0.txc = lane_ctrl[CTRL_W-1:0];
        term.word1.txd = lane_byte[2*CTRL_W-1:CTRL_W];
        term.word1.txc = lane_ctrl[2*CTRL_W-1:CTRL_W];
        term.two_words = two_words;

        // idle bytes that follow the terminate in the final word
        if (two_words) begin
            term.ifg_offset = 8'(11 - data_bytes);
        end else begin
            term.ifg_offset = 8'(3 - data_bytes);
        end
    end

endmodule

/* hdl/xgmii_tx_pkg.sv */
// xgmii transmitter shared definitions
package xgmii_tx_pkg;

    // bus geometry
    localparam int unsigned DATA_W = 64;
    localparam int unsigned CTRL_W = 8;
    localparam int unsigned EMPTY_W = 3;

    // ethernet framing bytes
    localparam logic [7:0] ETH_PRE = 8'h55;
    localparam logic [7:0] ETH_SFD = 8'hd5;

    // xgmii control characters
    localparam logic [7:0] XGMII_IDLE = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    // minimum inter-frame gap in bytes
    localparam logic [7:0] MIN_IFG = 8'd12;

    typedef enum logic [2:0] {
        IDLE,
        PAYLOAD,
        PAD,
        FCS_1,
        FCS_2,
        ERR,
        IFG
    } tx_state_e;

    // one input beat, tvalid and tready travel separately
    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [CTRL_W-1:0] tkeep;
        logic              tlast;
        logic              tuser;
    } tx_beat_t;

    typedef struct packed {
        logic [DATA_W-1:0] txd;
        logic [CTRL_W-1:0] txc;
    } xgmii_word_t;

    // entry n holds the crc over bytes 0..n
    typedef logic [7:0][31:0] crc_bank_t;

    typedef struct packed {
        xgmii_word_t word0;
        xgmii_word_t word1;
        logic        two_words;
        logic [7:0]  ifg_offset;
    } term_words_t;

endpackage

/* hdl/xgmii_tx_top.sv */
// xgmii frame transmitter top
`timescale 1ns/1ps

module xgmii_tx_top #(
    parameter bit PADDING_EN = 1'b1,
    parameter int MIN_FRAME_LEN = 64
) (
    input  logic                    clk,
    input  logic                    reset_crc,

    // frame input stream
    input  xgmii_tx_pkg::tx_beat_t  s_beat,
    input  logic                    s_tvalid,
    output logic                    s_tready,

    // configuration
    input  logic [7:0]              cfg_ifg,
    input  logic                    cfg_tx_enable,

    output xgmii_tx_pkg::xgmii_word_t xgmii_out,

    // status
    output logic                    start_packet,
    output logic                    error_underflow
);

    import xgmii_tx_pkg::*;

    logic               crc_init;
    logic               crc_update;
    logic [DATA_W-1:0]  cap_data;
    logic [EMPTY_W-1:0] cap_empty;
    crc_bank_t          crc_next;
    crc_bank_t          crc_held;
    term_words_t        term;

    tx_frame_ctrl #(
        .PADDING_EN(PADDING_EN),
        .MIN_FRAME_LEN(MIN_FRAME_LEN)
    ) i_tx_frame_ctrl (
        .clk(clk),
        .reset_crc(reset_crc),
        .s_beat(s_beat),
        .s_tvalid(s_tvalid),
        .s_tready(s_tready),
        .cfg_ifg(cfg_ifg),
        .cfg_tx_enable(cfg_tx_enable),
        .term(term),
        .crc_init(crc_init),
        .crc_update(crc_update),
        .cap_data(cap_data),
        .cap_empty(cap_empty),
        .xgmii_out(xgmii_out),
        .start_packet(start_packet),
        .error_underflow(error_underflow)
    );

    tx_crc32_bank i_tx_crc32_bank (
        .clk(clk),
        .crc_init(crc_init),
        .crc_update(crc_update),
        .cap_data(cap_data),
        .crc_next(crc_next),
        .crc_held(crc_held)
    );

    tx_term_encoder i_tx_term_encoder (
        .cap_data(cap_data),
        .cap_empty(cap_empty),
        .crc_next(crc_next),
        .crc_held(crc_held),
        .term(term)
    );

endmodule

/* tests/tb_clock_gen.sv */
// testbench clock source
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0);
            clk = ~clk;
        end
    end

endmodule

/* tests/tb_xgmii_tx.sv */
// xgmii transmitter testbench
`timescale 1ns/1ps

module tb_xgmii_tx;

    import xgmii_tx_pkg::*;

    localparam int MIN_LEN = 64;
    localparam int PAD_LEN = MIN_LEN - 4;
    localparam xgmii_word_t START_EXP = '{txd: {ETH_SFD, {6{ETH_PRE}}, XGMII_START},
                                          txc: 8'h01};
    localparam xgmii_word_t IDLE_EXP = '{txd: {8{XGMII_IDLE}}, txc: 8'hff};

    logic        clk;
    logic        reset_crc;
    tx_beat_t    s_beat;
    logic        s_tvalid;
    logic        s_tready;
    logic [7:0]  cfg_ifg;
    logic        cfg_tx_enable;
    xgmii_word_t xgmii_out;
    logic        start_packet;
    logic        error_underflow;

    // expected frames in the order they are sent
    // kind is 0 for a good frame, 1 for underflow and 2 for a bad frame
    logic [7:0]  exp_bytes[$];
    int          exp_len[$];
    int          exp_kind[$];

    logic [7:0]  rx_bytes[$];
    bit          in_frame;
    bit          rx_err;
    bit          rx_uf;
    int          idle_cnt;
    int          gap_need;
    int          sp_cnt;
    bit          chk_start, chk_end, quiet_chk;
    bit          hdr_ok, gap_ok, len_ok, data_ok, fcs_ok, kind_ok, sp_ok;

    tb_clock_gen #(.PERIOD_NS(40)) i_tb_clock_gen (.clk(clk));

    xgmii_tx_top #(
        .PADDING_EN(1'b1),
        .MIN_FRAME_LEN(MIN_LEN)
    ) i_xgmii_tx_top (
        .clk(clk),
        .reset_crc(reset_crc),
        .s_beat(s_beat),
        .s_tvalid(s_tvalid),
        .s_tready(s_tready),
        .cfg_ifg(cfg_ifg),
        .cfg_tx_enable(cfg_tx_enable),
        .xgmii_out(xgmii_out),
        .start_packet(start_packet),
        .error_underflow(error_underflow)
    );

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic report_error(input string msg);
        $display("%s at %0t ns", msg, $time);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    // one byte of the reflected ieee crc-32
    function automatic logic [31:0] crc32_step(input logic [31:0] crc_in,
                                               input logic [7:0] data);
        logic [31:0] crc;
        crc = crc_in;
        for (int b = 0; b < 8; b++) begin
            if (crc[0] ^ data[b]) begin
                crc = (crc >> 1) ^ 32'hedb88320;
            end else begin
                crc = crc >> 1;
            end
        end
        return crc;
    endfunction

    task automatic end_frame();
        int          kind;
        int          n;
        bit          size_ok;
        bit          dok;
        logic [7:0]  b;
        logic [31:0] fcs;
        logic [31:0] crc;
        in_frame = 1'b0;
        idle_cnt = 0;
        gap_need = (cfg_ifg > MIN_IFG) ? cfg_ifg : MIN_IFG;
        if (exp_kind.size() == 0) begin
            report_error("unexpected frame on the XGMII output");
        end
        kind = exp_kind.pop_front();
        n = exp_len.pop_front();
        size_ok = (rx_bytes.size() == n + 4);
        dok = 1'b1;
        fcs = 32'h0;
        crc = 32'hffffffff;
        if (kind == 0) begin
            for (int i = 0; i < n; i++) begin
                b = exp_bytes.pop_front();
                crc = crc32_step(crc, b);
                if (size_ok && rx_bytes[i] != b) begin
                    dok = 1'b0;
                end
            end
            if (size_ok) begin
                fcs = {rx_bytes[n+3], rx_bytes[n+2], rx_bytes[n+1], rx_bytes[n]};
            end
        end
        len_ok <= (kind != 0) || size_ok;
        data_ok <= dok;
        fcs_ok <= (kind != 0) || !size_ok || (fcs == ~crc);
        kind_ok <= (rx_err == (kind != 0)) && (rx_uf == (kind == 1));
        sp_ok <= (sp_cnt == 1);
        chk_end <= 1'b1;
    endtask

    task automatic scan_lane(input logic [7:0] d, input logic c);
        if (!in_frame) begin
            if (c && d == XGMII_IDLE) begin
                idle_cnt++;
            end
        end else if (!c) begin
            rx_bytes.push_back(d);
        end else if (d == XGMII_ERROR) begin
            rx_err = 1'b1;
        end else if (d == XGMII_TERM) begin
            end_frame();
        end
    endtask

    // output monitor
    always @(posedge clk) begin
        chk_start <= 1'b0;
        chk_end <= 1'b0;
        if (reset_crc) begin
            in_frame = 1'b0;
            idle_cnt = 1000;
            gap_need = MIN_IFG;
        end else if (!in_frame && xgmii_out.txc[0] && xgmii_out.txd[7:0] == XGMII_START) begin
            hdr_ok <= (xgmii_out == START_EXP);
            gap_ok <= (idle_cnt >= gap_need);
            chk_start <= 1'b1;
            in_frame = 1'b1;
            rx_err = 1'b0;
            rx_uf = 1'b0;
            sp_cnt = 0;
            rx_bytes.delete();
        end else begin
            if (in_frame && start_packet) begin
                sp_cnt++;
            end
            if (in_frame && error_underflow) begin
                rx_uf = 1'b1;
            end
            for (int i = 0; i < CTRL_W; i++) begin
                scan_lane(xgmii_out.txd[8*i +: 8], xgmii_out.txc[i]);
            end
        end
    end

    always @(posedge clk) begin
        if (i_xgmii_tx_top.i_xgmii_tx_asserts.fail_count != 0) begin
            report_error("a protocol assertion on the DUT failed");
        end
    end

    a_header: assert property (@(posedge clk) disable iff (reset_crc) chk_start |-> hdr_ok)
        else report_mismatch("start word is not start, preamble and SFD");
    a_gap: assert property (@(posedge clk) disable iff (reset_crc) chk_start |-> gap_ok)
        else report_mismatch("inter-frame gap shorter than required");
    a_length: assert property (@(posedge clk) disable iff (reset_crc) chk_end |-> len_ok)
        else report_mismatch("frame length differs from expected");
    a_data: assert property (@(posedge clk) disable iff (reset_crc) chk_end |-> data_ok)
        else report_mismatch("frame payload differs from expected");
    a_fcs: assert property (@(posedge clk) disable iff (reset_crc) chk_end |-> fcs_ok)
        else report_mismatch("FCS differs from computed CRC-32");
    a_ending: assert property (@(posedge clk) disable iff (reset_crc) chk_end |-> kind_ok)
        else report_mismatch("error word or underflow pulse not as expected");
    a_start_pulse: assert property (@(posedge clk) disable iff (reset_crc) chk_end |-> sp_ok)
        else report_mismatch("start_packet did not pulse once in the frame");
    a_quiet: assert property (@(posedge clk) disable iff (reset_crc)
        quiet_chk |-> (!s_tready && xgmii_out == IDLE_EXP))
        else report_mismatch("DUT active while transmit is disabled");

    task automatic wait_ready();
        int t;
        t = 0;
        while (!s_tready) begin
            @(posedge clk);
            #2;
            t++;
            if (t > 200) begin
                report_error("timeout waiting for s_tready");
            end
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_kind.size() != 0 || in_frame) begin
            @(posedge clk);
            #2;
            t++;
            if (t > 500) begin
                report_error("timeout waiting for frames to leave the DUT");
            end
        end
    endtask

    task automatic send_frame(input int len, input int kind);
        logic [7:0] data[$];
        tx_beat_t   beat;
        int         nbeats;
        int         pause;
        nbeats = (len + 7) / 8;
        for (int i = 0; i < len; i++) begin
            data.push_back(8'($urandom));
        end
        exp_kind.push_back(kind);
        exp_len.push_back((len < PAD_LEN) ? PAD_LEN : len);
        if (kind == 0) begin
            for (int i = 0; i < exp_len[$]; i++) begin
                exp_bytes.push_back((i < len) ? data[i] : 8'h00);
            end
        end
        for (int k = 0; k < nbeats; k++) begin
            // lanes past tkeep carry junk
            beat.tdata = {$urandom, $urandom};
            beat.tkeep = '0;
            for (int i = 0; i < CTRL_W; i++) begin
                if (8*k + i < len) begin
                    beat.tdata[8*i +: 8] = data[8*k + i];
                    beat.tkeep[i] = 1'b1;
                end
            end
            beat.tlast = (k == nbeats - 1);
            beat.tuser = beat.tlast && (kind == 2);
            if (kind == 1 && k == 3) begin
                s_tvalid = 1'b0;
                @(posedge clk);
                #2;
            end
            s_beat = beat;
            s_tvalid = 1'b1;
            wait_ready();
            @(posedge clk);
            #2;
        end
        s_tvalid = 1'b0;
        pause = $urandom % 4;
        repeat (pause) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        void'($urandom(11));
        reset_crc = 1'b1;
        s_beat = '0;
        s_tvalid = 1'b0;
        cfg_ifg = 8'd12;
        cfg_tx_enable = 1'b1;
        quiet_chk = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset_crc = 1'b0;

        // every tail alignment, then random lengths
        for (int a = 0; a < 8; a++) begin
            send_frame(64 + a + 8 * ($urandom % 17), 0);
        end
        for (int i = 0; i < 6; i++) begin
            send_frame(64 + $urandom % 137, 0);
        end
        for (int i = 0; i < 8; i++) begin
            send_frame(1 + $urandom % 59, 0);
        end
        send_frame(96, 1);
        send_frame(80, 2);
        send_frame(72, 0);
        wait_drain();

        cfg_ifg = 8'd20;
        for (int i = 0; i < 5; i++) begin
            send_frame(64 + $urandom % 137, 0);
        end
        wait_drain();

        // transmit disabled with a beat waiting
        cfg_tx_enable = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        quiet_chk = 1'b1;
        s_beat = '0;
        s_tvalid = 1'b1;
        repeat (20) @(posedge clk);
        #2;
        quiet_chk = 1'b0;
        s_tvalid = 1'b0;
        cfg_tx_enable = 1'b1;
        send_frame(64, 0);
        send_frame(30, 0);
        wait_drain();
        repeat (3) @(posedge clk);

        if (i_xgmii_tx_top.i_xgmii_tx_asserts.fail_count != 0) begin
            $display("TEST FAILED");
            $fatal(1, "protocol assertions failed");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

/* tests/xgmii_tx_asserts.sv */
// transmitter protocol assertions
`timescale 1ns/1ps

module xgmii_tx_asserts (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  logic                      s_tready,
    input  xgmii_tx_pkg::xgmii_word_t xgmii_out,
    input  logic                      start_packet,
    input  logic                      error_underflow
);

    import xgmii_tx_pkg::*;

    int fail_count = 0;

    // no ready while held in reset
    a_ready_reset: assert property (@(posedge clk) reset_crc |=> !s_tready)
        else begin
            $error("s_tready is high during reset");
            fail_count++;
        end

    a_start_single: assert property (@(posedge clk) disable iff (reset_crc)
        start_packet |=> !start_packet)
        else begin
            $error("start_packet high for two cycles in a row");
            fail_count++;
        end

    a_underflow_single: assert property (@(posedge clk) disable iff (reset_crc)
        error_underflow |=> !error_underflow)
        else begin
            $error("error_underflow high for two cycles in a row");
            fail_count++;
        end

    // start word is always followed by a data word
    a_after_start: assert property (@(posedge clk) disable iff (reset_crc)
        (xgmii_out.txc[0] && xgmii_out.txd[7:0] == XGMII_START) |=> xgmii_out.txc == 8'h00)
        else begin
            $error("word after the start character has control bits set");
            fail_count++;
        end

endmodule

bind xgmii_tx_top xgmii_tx_asserts i_xgmii_tx_asserts (
    .clk(clk),
    .reset_crc(reset_crc),
    .s_tready(s_tready),
    .xgmii_out(xgmii_out),
    .start_packet(start_packet),
    .error_underflow(error_underflow)
);

/* xgmii_tx.f */
hdl/xgmii_tx_pkg.sv
hdl/tx_crc32_bank.sv
hdl/tx_term_encoder.sv
hdl/tx_frame_ctrl.sv
hdl/xgmii_tx_top.sv
tests/tb_clock_gen.sv
tests/xgmii_tx_asserts.sv
tests/tb_xgmii_tx.sv
